//--- Makefile
VERILATOR  = verilator
TOP        = tb_ets_top
RTL_TOP    = ets_top
FILELIST   = list.f
BUILD_DIR  = obj_dir
LINT_FLAGS = --lint-only --timing --timescale 1ns/1ps
SIM_FLAGS  = --binary --assert --timescale 1ns/1ps -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(wildcard src/*.sv) $(wildcard tb/*.sv tb/*.svh)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

//--- list.f
+incdir+tb
src/ets_pkg.sv
src/ets_phase_sequencer.sv
src/ets_channel.sv
src/ets_readout_regs.sv
src/ets_top.sv
tb/tb_ets_top.sv

//--- src/ets_channel.sv
`timescale 1ns/1ps

module ets_channel import ets_pkg::*; (
	input  logic       sys_clk,
	input  logic       rst_n,
	input  logic       cmp_data,
	input  logic       sweep_start_ch,
	input  logic       acq_valid,
	input  logic       acq_last,
	input  step_t      step,
	input  hit_count_t threshold,
	input  step_t      mem_rd_addr,
	output hit_count_t mem_rd_data,
	output amp_t       amplitude
);

	logic [SYNC_STAGES-1:0] cmp_sync;
	logic [SYNC_STAGES-1:0] valid_dly;
	logic [SYNC_STAGES-1:0] last_dly;
	step_t                  step_dly [SYNC_STAGES];
	logic                   cmp_bit;
	logic                   win_valid;
	logic                   win_last;
	step_t                  win_step;
	hit_count_t             hit_cnt;
	hit_count_t             hit_total;
	hit_count_t             thresh_lat;
	hit_count_t             mem [NUM_STEPS];

	////////////////////////////////////////
	// synchronizer and strobe alignment
	////////////////////////////////////////

	always_ff @(posedge sys_clk or negedge rst_n) begin
		if (!rst_n) begin
			cmp_sync  <= '0;
			valid_dly <= '0;
			last_dly  <= '0;
		end else begin
			cmp_sync  <= {cmp_sync[SYNC_STAGES-2:0], cmp_data};
			valid_dly <= {valid_dly[SYNC_STAGES-2:0], acq_valid};
			last_dly  <= {last_dly[SYNC_STAGES-2:0], acq_last};
		end
	end

	always_ff @(posedge sys_clk) begin
		step_dly[0] <= step;
		for (int i = 1; i < SYNC_STAGES; i++)
			step_dly[i] <= step_dly[i-1];
	end

	assign cmp_bit   = cmp_sync[SYNC_STAGES-1];
	assign win_valid = valid_dly[SYNC_STAGES-1];  // lines up with cmp_bit
	assign win_last  = last_dly[SYNC_STAGES-1];
	assign win_step  = step_dly[SYNC_STAGES-1];

	////////////////////////////////////////
	// hit count and amplitude
	////////////////////////////////////////

	assign hit_total = hit_cnt + hit_count_t'(cmp_bit);

	always_ff @(posedge sys_clk or negedge rst_n) begin
		if (!rst_n) begin
			hit_cnt    <= '0;
			thresh_lat <= '0;
			amplitude  <= '0;
		end else begin
			if (win_last)
				hit_cnt <= '0;  // ready for the next step
			else if (win_valid)
				hit_cnt <= hit_total;

			if (sweep_start_ch) begin
				thresh_lat <= threshold;  // held for the whole sweep
				amplitude  <= '0;
			end else if (win_last && hit_total >= thresh_lat) begin
				amplitude <= amplitude + 1'b1;
			end
		end
	end

	// sample memory, one word per step
	always_ff @(posedge sys_clk) begin
		if (win_last)
			mem[win_step] <= hit_total;
		mem_rd_data <= mem[mem_rd_addr];
	end

	// window length comes from the sequencer
	a_hit_range: assert property (@(posedge sys_clk) disable iff (!rst_n)
		win_valid |-> hit_total <= hit_count_t'(WINDOW_LEN));

endmodule

//--- src/ets_phase_sequencer.sv
`timescale 1ns/1ps

module ets_phase_sequencer import ets_pkg::*; (
	input  logic  sys_clk,
	input  logic  rst_n,
	input  logic  sweep_start,
	input  logic  ps_done,
	output logic  ps_en,
	output logic  sweep_start_ch,
	output logic  acq_valid,
	output logic  acq_last,
	output step_t step,
	output logic  busy,
	output logic  sweep_done
);

	seq_state_t state;
	seq_state_t state_next;
	win_cnt_t   cnt;
	logic       win_end;
	logic       drain_end;
	logic       last_step;

	assign win_end   = cnt == win_cnt_t'(WINDOW_LEN - 1);
	assign drain_end = cnt == win_cnt_t'(SYNC_STAGES);  // SYNC_STAGES+1 drain cycles
	assign last_step = step == step_t'(NUM_STEPS - 1);

	////////////////////////////////////////
	// next state
	////////////////////////////////////////

	always_comb begin
		state_next = state;
		case (state)
			IDLE: begin
				if (sweep_start)
					state_next = SHIFT;
			end
			SHIFT: state_next = WAIT_DONE;
			WAIT_DONE: begin
				if (ps_done)
					state_next = ACQUIRE;  // window opens next cycle
			end
			ACQUIRE: begin
				if (win_end)
					state_next = DRAIN;
			end
			DRAIN: begin
				if (drain_end)
					state_next = last_step ? FINISH : SHIFT;
			end
			FINISH: state_next = IDLE;
			default: state_next = IDLE;
		endcase
	end

	always_ff @(posedge sys_clk or negedge rst_n) begin
		if (!rst_n) begin
			state          <= IDLE;
			cnt            <= '0;
			step           <= '0;
			ps_en          <= 1'b0;
			sweep_start_ch <= 1'b0;
		end else begin
			state          <= state_next;
			ps_en          <= (state == IDLE && sweep_start) ||
				(state == DRAIN && drain_end && !last_step);  // one pulse per step
			sweep_start_ch <= state == IDLE && sweep_start;

			if (state_next != state)
				cnt <= '0;
			else if (state == ACQUIRE || state == DRAIN)
				cnt <= cnt + 1'b1;

			if (state == IDLE && sweep_start)
				step <= '0;
			else if (state == DRAIN && drain_end && !last_step)
				step <= step + 1'b1;  // always stepping upward
		end
	end

	assign acq_valid  = state == ACQUIRE;
	assign acq_last   = acq_valid && win_end;
	assign busy       = state != IDLE && state != FINISH;
	assign sweep_done = state == FINISH;

	////////////////////////////////////////
	// checks
	////////////////////////////////////////

	a_ps_en_shift: assert property (@(posedge sys_clk) disable iff (!rst_n)
		ps_en |-> state == SHIFT);

	// window never overruns its length
	a_window_len: assert property (@(posedge sys_clk) disable iff (!rst_n)
		acq_valid [*WINDOW_LEN] |=> !acq_valid);

endmodule

//--- src/ets_pkg.sv
package ets_pkg;

	////////////////////////////////////////
	// sweep geometry
	////////////////////////////////////////

	localparam int NUM_CHANNELS = 3;   // ref path, s11, s21
	localparam int NUM_STEPS    = 64;  // phase steps per sweep
	localparam int WINDOW_LEN   = 16;  // clocks per acquisition window
	localparam int SYNC_STAGES  = 2;   // comparator synchronizer depth
	localparam int WIN_CNT_W    = $clog2(WINDOW_LEN);

	typedef logic [$clog2(NUM_STEPS)-1:0]      step_t;       // phase step index
	typedef logic [$clog2(WINDOW_LEN+1)-1:0]   hit_count_t;  // 0..WINDOW_LEN
	typedef logic [$clog2(NUM_STEPS+1)-1:0]    amp_t;        // steps over threshold
	typedef logic [7:0]                        reg_addr_t;   // word address
	typedef logic [31:0]                       reg_data_t;
	typedef logic [1:0]                        chan_t;
	typedef logic [WIN_CNT_W-1:0]              win_cnt_t;    // window and drain counter

	////////////////////////////////////////
	// register map, word addresses
	////////////////////////////////////////

	localparam reg_addr_t REG_CTRL        = 8'd0;   // bit 0 starts a sweep
	localparam reg_addr_t REG_THRESH_BASE = 8'd1;   // one per channel
	localparam reg_addr_t REG_AMP_BASE    = 8'd4;   // one per channel
	localparam reg_addr_t REG_STATUS      = 8'd7;   // busy, done
	localparam reg_addr_t MEM_BASE        = 8'd64;  // NUM_STEPS words per channel

	typedef enum logic [2:0] {
		IDLE,
		SHIFT,      // phase step requested
		WAIT_DONE,  // clock manager still shifting
		ACQUIRE,
		DRAIN,      // channel pipelines flush
		FINISH
	} seq_state_t;

endpackage

//--- src/ets_readout_regs.sv
`timescale 1ns/1ps

module ets_readout_regs import ets_pkg::*; (
	input  logic       sys_clk,
	input  logic       rst_n,
	input  logic       reg_wr,
	input  logic       reg_rd,
	input  reg_addr_t  reg_addr,
	input  reg_data_t  reg_wdata,
	output reg_data_t  reg_rdata,
	output logic       reg_rvalid,
	output logic       sweep_start,
	output hit_count_t thresholds [NUM_CHANNELS],
	input  logic       busy,
	input  logic       sweep_done,
	input  amp_t       amplitudes [NUM_CHANNELS],
	output step_t      mem_rd_addr,
	input  hit_count_t mem_rd_data [NUM_CHANNELS]
);

	logic      done;
	logic      is_mem;
	chan_t     mem_chan;
	reg_data_t reg_word;
	logic      rd_mem_q;
	chan_t     rd_chan_q;
	reg_data_t rd_word_q;

	// memory window is NUM_STEPS words per channel
	assign is_mem      = reg_addr >= MEM_BASE;
	assign mem_chan    = chan_t'((reg_addr - MEM_BASE) >> $bits(step_t));
	assign mem_rd_addr = step_t'(reg_addr);

	////////////////////////////////////////
	// writes
	////////////////////////////////////////

	always_ff @(posedge sys_clk or negedge rst_n) begin
		if (!rst_n) begin
			sweep_start <= 1'b0;
			done        <= 1'b0;
			for (int c = 0; c < NUM_CHANNELS; c++)
				thresholds[c] <= '0;
		end else begin
			sweep_start <= reg_wr && reg_addr == REG_CTRL && reg_wdata[0];

			if (sweep_done)
				done <= 1'b1;  // sticky until next start
			else if (sweep_start)
				done <= 1'b0;

			for (int c = 0; c < NUM_CHANNELS; c++) begin
				if (reg_wr && reg_addr == reg_addr_t'(REG_THRESH_BASE + c))
					thresholds[c] <= hit_count_t'(reg_wdata);
			end
		end
	end

	////////////////////////////////////////
	// reads
	////////////////////////////////////////

	always_comb begin
		reg_word = '0;  // unmapped reads as zero
		if (reg_addr == REG_STATUS)
			reg_word = reg_data_t'({done, busy});
		for (int c = 0; c < NUM_CHANNELS; c++) begin
			if (reg_addr == reg_addr_t'(REG_THRESH_BASE + c))
				reg_word = reg_data_t'(thresholds[c]);
			if (reg_addr == reg_addr_t'(REG_AMP_BASE + c))
				reg_word = reg_data_t'(amplitudes[c]);
		end
	end

	always_ff @(posedge sys_clk or negedge rst_n) begin
		if (!rst_n) begin
			reg_rvalid <= 1'b0;
			rd_mem_q   <= 1'b0;
		end else begin
			reg_rvalid <= reg_rd;
			if (reg_rd)
				rd_mem_q <= is_mem;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (reg_rd) begin
			rd_chan_q <= mem_chan;
			rd_word_q <= reg_word;
		end
	end

	// channel memories register their word on the same edge
	assign reg_rdata = rd_mem_q ? reg_data_t'(mem_rd_data[rd_chan_q]) : rd_word_q;

endmodule

//--- src/ets_top.sv
`timescale 1ns/1ps

module ets_top import ets_pkg::*; (
	input  logic                    sys_clk,
	input  logic                    rst_n,
	input  logic [NUM_CHANNELS-1:0] cmp_data,   // 0 ref, 1 s11, 2 s21
	input  logic                    reg_wr,
	input  logic                    reg_rd,
	input  reg_addr_t               reg_addr,
	input  reg_data_t               reg_wdata,
	output reg_data_t               reg_rdata,
	output logic                    reg_rvalid,
	output logic                    ps_en,      // to clock manager
	input  logic                    ps_done
);

	logic       sweep_start;
	logic       sweep_start_ch;
	logic       acq_valid;
	logic       acq_last;
	step_t      step;
	logic       busy;
	logic       sweep_done;
	step_t      mem_rd_addr;
	hit_count_t thresholds  [NUM_CHANNELS];
	amp_t       amplitudes  [NUM_CHANNELS];
	hit_count_t mem_rd_data [NUM_CHANNELS];

	ets_phase_sequencer u_seq (
		.sys_clk        (sys_clk),
		.rst_n          (rst_n),
		.sweep_start    (sweep_start),
		.ps_done        (ps_done),
		.ps_en          (ps_en),
		.sweep_start_ch (sweep_start_ch),
		.acq_valid      (acq_valid),
		.acq_last       (acq_last),
		.step           (step),
		.busy           (busy),
		.sweep_done     (sweep_done)
	);

	////////////////////////////////////////
	// comparator channels
	////////////////////////////////////////

	for (genvar c = 0; c < NUM_CHANNELS; c++) begin : g_chan
		ets_channel u_chan (
			.sys_clk        (sys_clk),
			.rst_n          (rst_n),
			.cmp_data       (cmp_data[c]),
			.sweep_start_ch (sweep_start_ch),
			.acq_valid      (acq_valid),
			.acq_last       (acq_last),
			.step           (step),
			.threshold      (thresholds[c]),
			.mem_rd_addr    (mem_rd_addr),    // shared read address
			.mem_rd_data    (mem_rd_data[c]),
			.amplitude      (amplitudes[c])
		);
	end

	ets_readout_regs u_regs (
		.sys_clk     (sys_clk),
		.rst_n       (rst_n),
		.reg_wr      (reg_wr),
		.reg_rd      (reg_rd),
		.reg_addr    (reg_addr),
		.reg_wdata   (reg_wdata),
		.reg_rdata   (reg_rdata),
		.reg_rvalid  (reg_rvalid),
		.sweep_start (sweep_start),
		.thresholds  (thresholds),
		.busy        (busy),
		.sweep_done  (sweep_done),
		.amplitudes  (amplitudes),
		.mem_rd_addr (mem_rd_addr),
		.mem_rd_data (mem_rd_data)
	);

endmodule

//--- tb/tb_ets_model.svh
`ifndef TB_ETS_MODEL_SVH
`define TB_ETS_MODEL_SVH

////////////////////////////////////////
// random source and reference model
////////////////////////////////////////

function automatic logic [31:0] xorshift32(input logic [31:0] x);
	logic [31:0] y;
	y = x;
	y = y ^ (y << 13);
	y = y ^ (y >> 17);
	y = y ^ (y << 5);
	return y;
endfunction

hit_count_t model_count [NUM_CHANNELS][NUM_STEPS];  // hits per channel and step
hit_count_t model_thresh [NUM_CHANNELS];            // thresholds written this sweep

// steps at or above the channel threshold
function automatic amp_t expected_amp(input int c);
	int n;
	n = 0;
	for (int s = 0; s < NUM_STEPS; s++) begin
		if (model_count[c][s] >= model_thresh[c])
			n++;
	end
	return amp_t'(n);
endfunction

////////////////////////////////////////
// compare tasks
////////////////////////////////////////

task automatic check_count(input hit_count_t got, input hit_count_t exp, input string what);
	if (got !== exp) begin
		$display("FAIL at %0t: %s read %0d, expected %0d", $time, what, got, exp);
		abort_run();
	end
endtask

task automatic check_amp(input amp_t got, input amp_t exp, input string what);
	if (got !== exp) begin
		$display("FAIL at %0t: %s read %0d, expected %0d", $time, what, got, exp);
		abort_run();
	end
endtask

task automatic check_status(input reg_data_t got, input reg_data_t exp, input string what);
	if (got !== exp) begin
		$display("FAIL at %0t: %s read 0x%08h, expected 0x%08h", $time, what, got, exp);
		abort_run();
	end
endtask

`endif

//--- tb/tb_ets_top.sv
`timescale 1ns/1ps

module tb_ets_top import ets_pkg::*; ();

	localparam logic [31:0] SEED   = 32'hdcdc0b17;
	localparam int NUM_SWEEPS      = 2;
	localparam int SWEEP_CYCLES    = 2 * NUM_STEPS * (WINDOW_LEN + 12);
	localparam int WATCHDOG_CYCLES = NUM_SWEEPS * SWEEP_CYCLES + 4000;  // margin for readback

	logic                    sys_clk;
	logic                    rst_n;
	logic [NUM_CHANNELS-1:0] cmp_data;
	logic                    reg_wr;
	logic                    reg_rd;
	reg_addr_t               reg_addr;
	reg_data_t               reg_wdata;
	reg_data_t               reg_rdata;
	logic                    reg_rvalid;
	logic                    ps_en;
	logic                    ps_done;

	logic [31:0]             rng_cmp;
	logic [31:0]             rng_ps;
	logic [31:0]             rng_main;
	logic [3:0]              cmp_level [NUM_CHANNELS];  // comparator density per channel
	logic [NUM_CHANNELS-1:0] cmp_next;
	int                      ps_en_count;
	int                      win_left;
	int                      model_step;
	hit_count_t              win_acc [NUM_CHANNELS];

	ets_top i_dut (
		.sys_clk    (sys_clk),
		.rst_n      (rst_n),
		.cmp_data   (cmp_data),
		.reg_wr     (reg_wr),
		.reg_rd     (reg_rd),
		.reg_addr   (reg_addr),
		.reg_wdata  (reg_wdata),
		.reg_rdata  (reg_rdata),
		.reg_rvalid (reg_rvalid),
		.ps_en      (ps_en),
		.ps_done    (ps_done)
	);

	task automatic abort_run();
		$display("FAIL: see errors above");
		$fatal(1, "run stopped on the first error");
	endtask

	`include "tb_ets_model.svh"

	initial begin
		sys_clk = 1'b0;
		forever #10 sys_clk = ~sys_clk;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge sys_clk);
		$display("watchdog expired after %0d cycles, the sweeps never finished", WATCHDOG_CYCLES);
		abort_run();
	end

	////////////////////////////////////////
	// comparators and clock manager
	////////////////////////////////////////

	always @(posedge sys_clk) begin
		rng_cmp = xorshift32(rng_cmp);
		for (int c = 0; c < NUM_CHANNELS; c++)
			cmp_next[c] = rng_cmp[4*c +: 4] < cmp_level[c];
		cmp_data <= cmp_next;
	end

	// phase shift completes 1 to 8 cycles after the request
	always @(posedge sys_clk) begin
		if (ps_en) begin
			rng_ps = xorshift32(rng_ps);
			repeat (rng_ps[2:0]) @(posedge sys_clk);
			ps_done <= 1'b1;
			@(posedge sys_clk);
			ps_done <= 1'b0;
		end
	end

	// records the bits on the WINDOW_LEN edges after each ps_done
	always @(posedge sys_clk) begin
		if (ps_en)
			ps_en_count++;
		if (win_left > 0) begin
			for (int c = 0; c < NUM_CHANNELS; c++)
				win_acc[c] = win_acc[c] + hit_count_t'(cmp_data[c]);
			win_left = win_left - 1;
			if (win_left == 0) begin
				if (model_step >= NUM_STEPS) begin
					$display("more acquisition windows than phase steps in one sweep");
					abort_run();
				end else begin
					for (int c = 0; c < NUM_CHANNELS; c++)
						model_count[c][model_step] = win_acc[c];
					model_step++;
				end
			end
		end
		if (ps_done) begin
			win_left = WINDOW_LEN;
			for (int c = 0; c < NUM_CHANNELS; c++)
				win_acc[c] = '0;
		end
	end

	////////////////////////////////////////
	// register access
	////////////////////////////////////////

	task automatic reg_write(input reg_addr_t addr, input reg_data_t data);
		@(posedge sys_clk);
		reg_wr    <= 1'b1;
		reg_addr  <= addr;
		reg_wdata <= data;
		@(posedge sys_clk);
		reg_wr <= 1'b0;
	endtask

	task automatic reg_read(input reg_addr_t addr, output reg_data_t data);
		@(posedge sys_clk);
		reg_rd   <= 1'b1;
		reg_addr <= addr;
		@(posedge sys_clk);
		reg_rd <= 1'b0;
		@(posedge sys_clk);
		if (!reg_rvalid) begin
			$display("no read-valid pulse one cycle after reading address %0d", addr);
			abort_run();
		end
		data = reg_rdata;  // address still held for memory words
	endtask

	task automatic wait_sweep_done();
		reg_data_t st;
		int        polls;
		st    = '0;
		polls = 0;
		while (!st[1] && polls < SWEEP_CYCLES / 3) begin
			reg_read(REG_STATUS, st);
			polls++;
		end
		if (!st[1]) begin
			$display("sweep never reported done in the status register");
			abort_run();
		end
	endtask

	task automatic run_sweep();
		reg_data_t rd;
		for (int c = 0; c < NUM_CHANNELS; c++) begin
			rng_main        = xorshift32(rng_main);
			model_thresh[c] = hit_count_t'(rng_main[7:0] % 17);
			cmp_level[c]    = 4'(2 + rng_main[15:8] % 13);
			reg_write(reg_addr_t'(REG_THRESH_BASE + c), reg_data_t'(model_thresh[c]));
		end
		for (int c = 0; c < NUM_CHANNELS; c++) begin
			reg_read(reg_addr_t'(REG_THRESH_BASE + c), rd);
			check_count(hit_count_t'(rd), model_thresh[c], $sformatf("threshold %0d", c));
		end
		ps_en_count = 0;
		model_step  = 0;
		reg_write(REG_CTRL, 32'h1);
		reg_read(REG_STATUS, rd);
		check_status(rd, 32'h1, "status after start");
		for (int c = 0; c < NUM_CHANNELS; c++) begin
			reg_read(reg_addr_t'(REG_AMP_BASE + c), rd);
			check_amp(amp_t'(rd), '0, $sformatf("amplitude %0d after start", c));
		end
		reg_write(REG_CTRL, 32'h1);  // start while busy
		wait_sweep_done();
		if (ps_en_count != NUM_STEPS) begin
			$display("FAIL at %0t: %0d ps_en pulses, expected %0d", $time, ps_en_count,
				NUM_STEPS);
			abort_run();
		end
		reg_read(REG_STATUS, rd);
		check_status(rd, 32'h2, "status after sweep");
		for (int c = 0; c < NUM_CHANNELS; c++) begin
			for (int s = 0; s < NUM_STEPS; s++) begin
				reg_read(reg_addr_t'(int'(MEM_BASE) + NUM_STEPS * c + s), rd);
				check_count(hit_count_t'(rd), model_count[c][s],
					$sformatf("channel %0d step %0d", c, s));
			end
			reg_read(reg_addr_t'(REG_AMP_BASE + c), rd);
			check_amp(amp_t'(rd), expected_amp(c), $sformatf("amplitude %0d", c));
		end
	endtask

	////////////////////////////////////////
	// main sequence
	////////////////////////////////////////

	initial begin
		reg_data_t rd;
		rst_n       = 1'b0;
		cmp_data    = '0;
		ps_done     = 1'b0;
		reg_wr      = 1'b0;
		reg_rd      = 1'b0;
		reg_addr    = '0;
		reg_wdata   = '0;
		rng_cmp     = SEED;
		rng_main    = xorshift32(SEED);
		rng_ps      = xorshift32(rng_main);
		ps_en_count = 0;
		win_left    = 0;
		model_step  = 0;
		for (int c = 0; c < NUM_CHANNELS; c++)
			cmp_level[c] = 4'd8;
		repeat (2) @(posedge sys_clk);
		rst_n <= 1'b1;

		reg_read(REG_STATUS, rd);
		check_status(rd, 32'h0, "status after reset");
		for (int c = 0; c < NUM_CHANNELS; c++) begin
			reg_read(reg_addr_t'(REG_AMP_BASE + c), rd);
			check_amp(amp_t'(rd), '0, $sformatf("amplitude %0d after reset", c));
		end
		if (ps_en_count != 0) begin
			$display("ps_en pulsed before any sweep was started");
			abort_run();
		end

		repeat (NUM_SWEEPS) run_sweep();

		$display("PASS: all tests");
		$finish;
	end

endmodule
